// ==== project.f ====
+incdir+tests
design/replay_pkg.sv
design/replay_alloc.sv
design/lane_store.sv
design/replay_sched.sv
design/replay_queue.sv
tests/tb_replay_queue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_replay_queue
FLAGS ?= --binary --timing --assert --timescale 1ns/1ns
OBJ_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLAGS OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f project.f --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_replay_model.svh ====
`ifndef TB_REPLAY_MODEL_SVH
`define TB_REPLAY_MODEL_SVH

// x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic [31:0] lfsr_state = 32'd99839;

// one entry as driven with a mask bit per lane
typedef struct packed {
  logic [LANES-1:0]        mask;
  load_op_t [LD_LANES-1:0] ld;
  store_op_t               st;
} entry_t;

// one op as seen on the output port
typedef struct packed {
  logic [LANE_W-1:0] lane;
  logic              is_store;
  logic [ADDR_W-1:0] addr;
  logic [REG_W-1:0]  reg_no;
  logic [SIZE_W-1:0] size;
  logic [TAG_W-1:0]  tag;
  logic [DATA_W-1:0] data;
} xfer_t;

function automatic logic lfsr_step();
  logic lsb;
  lsb = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (lsb) begin
    lfsr_state = lfsr_state ^ LFSR_TAPS;
  end
  return lsb;
endfunction

function automatic logic [63:0] rand_bits(input int n);
  logic [63:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[62:0], lfsr_step()};
  end
  return r;
endfunction

// lowest pending lane of the entry with the store lane last
function automatic xfer_t next_expected(input entry_t e);
  xfer_t x;
  logic [LANE_W-1:0] sel;
  x = '0;
  sel = '0;
  for (int i = LANES - 1; i >= 0; i--) begin
    if (e.mask[i]) begin
      sel = LANE_W'(i);
    end
  end
  x.lane = sel;
  if (sel == LANE_W'(LANES - 1)) begin
    x.is_store = 1'b1;
    x.addr = e.st.addr;
    x.reg_no = e.st.reg_no;
    x.size = e.st.size;
    x.data = e.st.data;
  end else begin
    x.addr = e.ld[sel].addr;
    x.reg_no = e.ld[sel].reg_no;
    x.size = e.ld[sel].size;
    x.tag = e.ld[sel].tag;
  end
  return x;
endfunction

`endif

// ==== tests/tb_replay_queue.sv ====
`timescale 1ns/1ns

module tb_replay_queue
  import replay_pkg::*;
();

  // random phase plus room for the directed tests and drains
  localparam int RAND_CYCLES = 300;
  localparam int RUN_CYCLES = RAND_CYCLES + 200;
  localparam int CYCLE_LIMIT = 4 * RUN_CYCLES;

  logic              clk;
  logic              rst;
  logic              except;
  logic              ld_conflict [LD_LANES];
  logic [ADDR_W-1:0] ld_addr [LD_LANES];
  logic [REG_W-1:0]  ld_reg [LD_LANES];
  logic [SIZE_W-1:0] ld_size [LD_LANES];
  logic [TAG_W-1:0]  ld_tag [LD_LANES];
  logic              st_conflict;
  logic [ADDR_W-1:0] st_addr;
  logic [REG_W-1:0]  st_reg;
  logic [SIZE_W-1:0] st_size;
  logic [DATA_W-1:0] st_data;
  logic              out_ready;
  logic              out_valid;
  logic [LANE_W-1:0] out_lane;
  logic              out_is_store;
  logic [ADDR_W-1:0] out_addr;
  logic [REG_W-1:0]  out_reg;
  logic [SIZE_W-1:0] out_size;
  logic [TAG_W-1:0]  out_tag;
  logic [DATA_W-1:0] out_data;
  logic              skip;

  `include "tb_replay_model.svh"

  entry_t ent_q [$];
  int     errors = 0;
  int     err_base = 0;
  int     transfers = 0;
  int     cycle_count = 0;
  logic   hold_valid = 1'b0;
  xfer_t  hold_op;

  replay_queue replay_queue_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic xfer_t observed();
    xfer_t x;
    x = {out_lane, out_is_store, out_addr, out_reg, out_size, out_tag, out_data};
    return x;
  endfunction

  function automatic entry_t rand_entry(input logic [LANES-1:0] mask);
    entry_t e;
    e.mask = mask;
    for (int i = 0; i < LD_LANES; i++) begin
      e.ld[i].addr = ADDR_W'(rand_bits(ADDR_W));
      e.ld[i].reg_no = REG_W'(rand_bits(REG_W));
      e.ld[i].size = SIZE_W'(rand_bits(SIZE_W));
      e.ld[i].tag = TAG_W'(rand_bits(TAG_W));
    end
    e.st.addr = ADDR_W'(rand_bits(ADDR_W));
    e.st.reg_no = REG_W'(rand_bits(REG_W));
    e.st.size = SIZE_W'(rand_bits(SIZE_W));
    e.st.data = rand_bits(DATA_W);
    return e;
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  // flagged entries go to the expected queue when tracked
  task automatic send(input entry_t e, input bit track);
    for (int i = 0; i < LD_LANES; i++) begin
      ld_conflict[i] <= e.mask[i];
      ld_addr[i] <= e.ld[i].addr;
      ld_reg[i] <= e.ld[i].reg_no;
      ld_size[i] <= e.ld[i].size;
      ld_tag[i] <= e.ld[i].tag;
    end
    st_conflict <= e.mask[LANES-1];
    st_addr <= e.st.addr;
    st_reg <= e.st.reg_no;
    st_size <= e.st.size;
    st_data <= e.st.data;
    if (track && e.mask != '0) begin
      ent_q.push_back(e);
    end
  endtask

  task automatic wait_drain();
    do begin
      @(negedge clk);
    end while (ent_q.size() != 0 || out_valid);
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - err_base);
    err_base = errors;
  endtask

  // compare each transfer against the model, and held ops against the last cycle
  always @(posedge clk) begin
    xfer_t  obs;
    xfer_t  exp;
    entry_t head;
    obs = observed();
    if (!rst) begin
      if (hold_valid && (out_valid !== 1'b1 || obs !== hold_op)) begin
        report_mismatch("output changed while out_ready was low");
      end
      if (out_valid && out_ready) begin
        transfers++;
        if (ent_q.size() == 0) begin
          errors++;
          $display("ERROR at %0t: lane %0d replayed with no flagged op waiting", $time, out_lane);
        end else begin
          head = ent_q.pop_front();
          exp = next_expected(head);
          if (obs !== exp) begin
            report_mismatch($sformatf("expected op %h, got %h", exp, obs));
          end
          head.mask[exp.lane] = 1'b0;
          if (head.mask != '0) begin
            ent_q.push_front(head);
          end
        end
      end
    end
    hold_valid = out_valid && !out_ready && !except && !rst;
    hold_op = obs;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    rst <= 1'b1;
    except <= 1'b0;
    out_ready <= 1'b1;
    send(rand_entry('0), 1'b0);
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    if (out_valid !== 1'b0 || skip !== 1'b0) begin
      report_mismatch("out_valid or skip high after reset");
    end
    @(posedge clk);
    send(rand_entry(4'b0001), 1'b1);
    @(posedge clk);
    send(rand_entry('0), 1'b1);
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      report_mismatch("load visible one edge after capture");
    end
    @(negedge clk);
    if (out_valid !== 1'b1) begin
      report_mismatch("load not visible two edges after capture");
    end
    wait_drain();
    finish_test(1, "reset and single load");

    @(posedge clk);
    send(rand_entry(4'b1111), 1'b1);
    @(posedge clk);
    send(rand_entry('0), 1'b1);
    wait_drain();
    finish_test(2, "all four lanes in order");

    for (int n = 0; n < RAND_CYCLES; n++) begin
      @(posedge clk);
      out_ready <= 1'(rand_bits(1));
      if (skip) begin
        send(rand_entry('0), 1'b1);
      end else begin
        send(rand_entry(LANES'(rand_bits(LANES))), 1'b1);
      end
    end
    @(posedge clk);
    out_ready <= 1'b1;
    send(rand_entry('0), 1'b1);
    wait_drain();
    finish_test(3, "random masks and ready");

    @(posedge clk);
    out_ready <= 1'b0;
    for (int n = 0; n < STALL_COUNT; n++) begin
      send(rand_entry(4'b0101), 1'b1);
      @(posedge clk);
    end
    send(rand_entry('0), 1'b1);
    repeat (4) @(negedge clk);
    if (skip !== 1'b1) begin
      report_mismatch("skip low with the stall count stored");
    end
    @(posedge clk);
    out_ready <= 1'b1;
    do begin
      @(negedge clk);
      if (skip !== 1'b1) begin
        report_mismatch("skip dropped before the queue drained");
      end
    end while (ent_q.size() != 0);
    repeat (2) @(negedge clk);
    if (skip !== 1'b0) begin
      report_mismatch("skip still high after the queue drained");
    end
    finish_test(4, "skip set and clear");

    @(posedge clk);
    out_ready <= 1'b0;
    repeat (3) begin
      send(rand_entry(4'b1010), 1'b1);
      @(posedge clk);
    end
    // this one sits in the capture stage when the flush hits
    send(rand_entry(4'b1011), 1'b0);
    @(posedge clk);
    except <= 1'b1;
    send(rand_entry(4'b0110), 1'b0);
    ent_q.delete();
    @(posedge clk);
    except <= 1'b0;
    send(rand_entry('0), 1'b0);
    @(posedge clk);
    out_ready <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        report_mismatch("out_valid high after flush");
      end
    end
    @(posedge clk);
    send(rand_entry(4'b1001), 1'b1);
    @(posedge clk);
    send(rand_entry('0), 1'b1);
    wait_drain();
    finish_test(5, "exception flush");

    repeat (20) begin
      @(posedge clk);
      out_ready <= 1'(rand_bits(1));
      send(rand_entry('0), 1'b1);
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        report_mismatch("unflagged op reached the output");
      end
    end
    finish_test(6, "unflagged ops ignored");

    $display("transfers checked %0d, errors %0d", transfers, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== design/replay_queue.sv ====
`timescale 1ns/1ns

module replay_queue
  import replay_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              except,
  input  logic              ld_conflict [LD_LANES],
  input  logic [ADDR_W-1:0] ld_addr [LD_LANES],
  input  logic [REG_W-1:0]  ld_reg [LD_LANES],
  input  logic [SIZE_W-1:0] ld_size [LD_LANES],
  input  logic [TAG_W-1:0]  ld_tag [LD_LANES],
  input  logic              st_conflict,
  input  logic [ADDR_W-1:0] st_addr,
  input  logic [REG_W-1:0]  st_reg,
  input  logic [SIZE_W-1:0] st_size,
  input  logic [DATA_W-1:0] st_data,
  input  logic              out_ready,
  output logic              out_valid,
  output logic [LANE_W-1:0] out_lane,
  output logic              out_is_store,
  output logic [ADDR_W-1:0] out_addr,
  output logic [REG_W-1:0]  out_reg,
  output logic [SIZE_W-1:0] out_size,
  output logic [TAG_W-1:0]  out_tag,
  output logic [DATA_W-1:0] out_data,
  output logic              skip
);

  logic             wr_en;
  logic [PTR_W-1:0] wr_ptr;
  load_op_t         wr_ld [LD_LANES];
  store_op_t        wr_st;
  logic [LANES-1:0] wr_pend;
  logic [PTR_W-1:0] head_ptr;
  logic [LANES-1:0] clr;
  logic             retire;
  load_op_t         head_ld [LD_LANES];
  store_op_t        head_st;
  logic [LANES-1:0] head_pend;

  replay_alloc alloc_inst (
    .clk         (clk),
    .rst         (rst),
    .except      (except),
    .ld_conflict (ld_conflict),
    .ld_addr     (ld_addr),
    .ld_reg      (ld_reg),
    .ld_size     (ld_size),
    .ld_tag      (ld_tag),
    .st_conflict (st_conflict),
    .st_addr     (st_addr),
    .st_reg      (st_reg),
    .st_size     (st_size),
    .st_data     (st_data),
    .retire      (retire),
    .wr_en       (wr_en),
    .wr_ptr      (wr_ptr),
    .wr_ld       (wr_ld),
    .wr_st       (wr_st),
    .wr_pend     (wr_pend),
    .skip        (skip)
  );

  // one store per load lane
  for (genvar i = 0; i < LD_LANES; i++) begin : g_ld_store
    lane_store #(.payload_t(load_op_t)) ld_store_inst (
      .clk       (clk),
      .rst       (rst),
      .except    (except),
      .wr_en     (wr_en),
      .wr_ptr    (wr_ptr),
      .wr_data   (wr_ld[i]),
      .wr_pend   (wr_pend[i]),
      .head_ptr  (head_ptr),
      .clr       (clr[i]),
      .head_data (head_ld[i]),
      .head_pend (head_pend[i])
    );
  end

  lane_store #(.payload_t(store_op_t)) st_store_inst (
    .clk       (clk),
    .rst       (rst),
    .except    (except),
    .wr_en     (wr_en),
    .wr_ptr    (wr_ptr),
    .wr_data   (wr_st),
    .wr_pend   (wr_pend[LANES-1]),
    .head_ptr  (head_ptr),
    .clr       (clr[LANES-1]),
    .head_data (head_st),
    .head_pend (head_pend[LANES-1])
  );

  replay_sched sched_inst (
    .clk          (clk),
    .rst          (rst),
    .except       (except),
    .head_ld      (head_ld),
    .head_st      (head_st),
    .head_pend    (head_pend),
    .out_ready    (out_ready),
    .head_ptr     (head_ptr),
    .clr          (clr),
    .retire       (retire),
    .out_valid    (out_valid),
    .out_lane     (out_lane),
    .out_is_store (out_is_store),
    .out_addr     (out_addr),
    .out_reg      (out_reg),
    .out_size     (out_size),
    .out_tag      (out_tag),
    .out_data     (out_data)
  );

endmodule

// ==== design/replay_sched.sv ====
`timescale 1ns/1ns

module replay_sched
  import replay_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              except,
  input  load_op_t          head_ld [LD_LANES],
  input  store_op_t         head_st,
  input  logic [LANES-1:0]  head_pend,
  input  logic              out_ready,
  output logic [PTR_W-1:0]  head_ptr,
  output logic [LANES-1:0]  clr,
  output logic              retire,
  output logic              out_valid,
  output logic [LANE_W-1:0] out_lane,
  output logic              out_is_store,
  output logic [ADDR_W-1:0] out_addr,
  output logic [REG_W-1:0]  out_reg,
  output logic [SIZE_W-1:0] out_size,
  output logic [TAG_W-1:0]  out_tag,
  output logic [DATA_W-1:0] out_data
);

  logic [LANES-1:0]  sel_hot;
  logic [LANE_W-1:0] sel_lane;
  logic              xfer;
  logic              last_lane;

  // isolate lowest pending lane
  assign sel_hot = head_pend & (~head_pend + 1'b1);

  always_comb begin
    sel_lane = '0;
    for (int i = 0; i < LANES; i++) begin
      if (sel_hot[i]) begin
        sel_lane = LANE_W'(i);
      end
    end
  end

  assign out_valid = |head_pend;
  assign out_lane = sel_lane;
  assign xfer = out_valid & out_ready;

  // nothing left behind the selected lane means the entry is done
  assign last_lane = (head_pend & ~sel_hot) == '0;

  assign clr = xfer ? sel_hot : '0;
  assign retire = xfer & last_lane;

  // payload mux
  always_comb begin
    out_is_store = 1'b0;
    out_addr = '0;
    out_reg = '0;
    out_size = '0;
    out_tag = '0;
    out_data = '0;
    if (sel_lane == LANE_W'(LD_LANES)) begin
      out_is_store = 1'b1;
      out_addr = head_st.addr;
      out_reg = head_st.reg_no;
      out_size = head_st.size;
      out_data = head_st.data;
    end else begin
      out_addr = head_ld[sel_lane].addr;
      out_reg = head_ld[sel_lane].reg_no;
      out_size = head_ld[sel_lane].size;
      out_tag = head_ld[sel_lane].tag;
    end
  end

  // alloc zeroes wr_ptr on the same flush
  always_ff @(posedge clk) begin
    if (rst || except) begin
      head_ptr <= '0;
    end else if (retire) begin
      head_ptr <= head_ptr + 1'b1;
    end
  end

  // held op must not change under back-pressure
  a_lane_stable: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready && !except) |=> (out_valid && $stable(out_lane))
  );

endmodule

// ==== design/lane_store.sv ====
`timescale 1ns/1ns

module lane_store
  import replay_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             except,
  input  logic             wr_en,
  input  logic [PTR_W-1:0] wr_ptr,
  input  payload_t         wr_data,
  input  logic             wr_pend,
  input  logic [PTR_W-1:0] head_ptr,
  input  logic             clr,
  output payload_t         head_data,
  output logic             head_pend
);

  payload_t         mem [DEPTH];
  logic [DEPTH-1:0] pend;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // write and clear never hit the same slot
  // an empty queue has nothing pending at the head
  always_ff @(posedge clk) begin
    if (rst || except) begin
      pend <= '0;
    end else begin
      if (clr) begin
        pend[head_ptr] <= 1'b0;
      end
      if (wr_en) begin
        pend[wr_ptr] <= wr_pend;
      end
    end
  end

  assign head_data = mem[head_ptr];
  assign head_pend = pend[head_ptr];

  // scheduler only clears a lane it saw pending
  a_clr_hits_pending: assert property (
    @(posedge clk) disable iff (rst) clr |-> pend[head_ptr]
  );

endmodule

// ==== design/replay_alloc.sv ====
`timescale 1ns/1ns

module replay_alloc
  import replay_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              except,
  input  logic              ld_conflict [LD_LANES],
  input  logic [ADDR_W-1:0] ld_addr [LD_LANES],
  input  logic [REG_W-1:0]  ld_reg [LD_LANES],
  input  logic [SIZE_W-1:0] ld_size [LD_LANES],
  input  logic [TAG_W-1:0]  ld_tag [LD_LANES],
  input  logic              st_conflict,
  input  logic [ADDR_W-1:0] st_addr,
  input  logic [REG_W-1:0]  st_reg,
  input  logic [SIZE_W-1:0] st_size,
  input  logic [DATA_W-1:0] st_data,
  input  logic              retire,
  output logic              wr_en,
  output logic [PTR_W-1:0]  wr_ptr,
  output load_op_t          wr_ld [LD_LANES],
  output store_op_t         wr_st,
  output logic [LANES-1:0]  wr_pend,
  output logic              skip
);

  logic [PTR_W:0] count;

  // capture stage
  always_ff @(posedge clk) begin
    for (int i = 0; i < LD_LANES; i++) begin
      wr_ld[i].addr <= ld_addr[i];
      wr_ld[i].reg_no <= ld_reg[i];
      wr_ld[i].size <= ld_size[i];
      wr_ld[i].tag <= ld_tag[i];
    end
    wr_st.addr <= st_addr;
    wr_st.reg_no <= st_reg;
    wr_st.size <= st_size;
    wr_st.data <= st_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_pend <= '0;
    end else begin
      for (int i = 0; i < LD_LANES; i++) begin
        wr_pend[i] <= ld_conflict[i] & ~except;
      end
      wr_pend[LANES-1] <= st_conflict & ~except;
    end
  end

  // flush also kills the op sitting in the capture stage
  assign wr_en = (|wr_pend) & ~except;

  always_ff @(posedge clk) begin
    if (rst || except) begin
      wr_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      case ({wr_en, retire})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // skip holds until the queue has fully drained
  always_ff @(posedge clk) begin
    if (rst) begin
      skip <= 1'b0;
    end else if (count >= (PTR_W + 1)'(STALL_COUNT)) begin
      skip <= 1'b1;
    end else if (count == '0) begin
      skip <= 1'b0;
    end
  end

  // a full queue would overwrite the entry under replay
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (rst) wr_en |-> count != (PTR_W + 1)'(DEPTH)
  );

endmodule

// ==== design/replay_pkg.sv ====
package replay_pkg;

  // queue geometry
  localparam int DEPTH = 8;
  localparam int PTR_W = 3;

  // lanes 0..2 are loads and the last lane is the store
  localparam int LD_LANES = 3;
  localparam int LANES = 4;
  localparam int LANE_W = 2;

  // op field widths
  localparam int ADDR_W = 44;
  localparam int REG_W = 9;
  localparam int SIZE_W = 5;
  localparam int TAG_W = 9;
  localparam int DATA_W = 64;

  // occupancy that raises skip
  localparam int STALL_COUNT = 4;

  // 67 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [REG_W-1:0]  reg_no;
    logic [SIZE_W-1:0] size;
    logic [TAG_W-1:0]  tag;
  } load_op_t;

  // 122 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [REG_W-1:0]  reg_no;
    logic [SIZE_W-1:0] size;
    logic [DATA_W-1:0] data;
  } store_op_t;

endpackage
